//--- sources.f
verilog/dodge_pkg.sv
verilog/board_if.sv
verilog/lane_picker.sv
verilog/block_field.sv
verilog/cell_painter.sv
verilog/game_control.sv
verilog/dodge_game.sv
verification/dodge_game_checker.sv
verification/dodge_game_tb.sv

//--- Bender.yml
package:
  name: dodge_game

sources:
  - verilog/dodge_pkg.sv
  - verilog/board_if.sv
  - verilog/lane_picker.sv
  - verilog/block_field.sv
  - verilog/cell_painter.sv
  - verilog/game_control.sv
  - verilog/dodge_game.sv
  - target: test
    files:
      - verification/dodge_game_checker.sv
      - verification/dodge_game_tb.sv

//--- verification/dodge_game_tb.sv
`timescale 1ns/1ps

module dodge_game_tb;
	import dodge_pkg::*;

	localparam int turn_cycles = 4404;
	localparam int max_turns = 48;
	localparam int cycle_limit = max_turns * turn_cycles + 4000; // restarts and idle time
	localparam int window = cell_size * cell_size;

	logic clock;
	logic reset;
	logic go;
	logic left;
	logic right;
	logic up;
	logic down;
	logic plot;
	logic [7:0] x;
	logic [6:0] y;
	colour_t colour;
	logic game_over;

	int errors = 0;
	int cycles = 0;
	int turns = 0;
	int overs = 0;
	int game_turn;
	int dir;
	int slot; // next slot to load
	int px;
	int py;
	int bx [block_slots];
	int by [block_slots];
	int painted_x;
	bit clamp_seen = 0;

	dodge_game dut_i (.*);

	always #4 clock = ~clock;

	always @(posedge clock)
	begin
		cycles++;
		if (cycles >= cycle_limit)
		begin
			$display("timeout: run did not end within %0d cycles", cycle_limit);
			$display("** FAIL **");
			$finish;
		end
	end

	task automatic check_value(string name, int expected, int actual);
		assert (expected == actual)
		else
		begin
			$display("Error at %0t: %s expected %0d, got %0d", $time, name, expected, actual);
			errors++;
		end
	endtask

	task automatic check_true(bit condition, string what);
		assert (condition)
		else
		begin
			$display("failure at %0t: %s", $time, what);
			errors++;
		end
	endtask

	// {left, right, up, down}, one quarter turn per direction step
	function automatic logic [3:0] rotate_keys(logic [3:0] keys, int steps);
		logic [3:0] k;
		k = keys;
		for (int i = 0; i < steps; i++)
			k = {k[1], k[0], k[2], k[3]};
		return k;
	endfunction

	function automatic bit on_grid(int cx, int cy);
		return cx >= x_first && cx <= x_last && (cx - x_first) % cell_pitch == 0
			&& cy >= y_first && cy <= y_last && (cy - y_first) % cell_pitch == 0;
	endfunction

	function automatic bit on_entry_edge(int cx, int cy, int d);
		if (!on_grid(cx, cy))
			return 0;
		case (d)
			0: return cy == y_first;
			1: return cx == x_last;
			2: return cy == y_last;
			default: return cx == x_first;
		endcase
	endfunction

	function automatic logic [3:0] random_keys();
		int pick;
		pick = $urandom % 5;
		return (pick == 4) ? 4'b0000 : 4'b0001 << pick;
	endfunction

	// steer across the lane of the newest block so that it runs into the player
	function automatic logic [3:0] chase_keys(int target);
		logic [3:0] want;
		want = 4'b0000;
		if (bx[target] != 0)
		begin
			if (dir == 0 || dir == 2)
				want = (bx[target] < px) ? 4'b1000 : ((bx[target] > px) ? 4'b0100 : 4'b0000);
			else
				want = (by[target] < py) ? 4'b0010 : ((by[target] > py) ? 4'b0001 : 4'b0000);
		end
		for (int k = 0; k < 4; k++)
			if (want != 0 && rotate_keys(4'b0001 << k, dir) == want)
				return 4'b0001 << k;
		return 4'b0000;
	endfunction

	task automatic restart_model();
		px = player_start[14:7];
		py = player_start[6:0];
		for (int i = 0; i < block_slots; i++)
		begin
			bx[i] = 0;
			by[i] = 0;
		end
		dir = 0;
		slot = 0;
		game_turn = 0;
	endtask

	task automatic move_player(logic [3:0] moves);
		int dx;
		int dy;
		dx = moves[2] ? cell_pitch : (moves[3] ? -cell_pitch : 0);
		dy = moves[0] ? cell_pitch : (moves[1] ? -cell_pitch : 0);
		if (on_grid(px + dx, py))
			px += dx; // clamp at the edge
		if (on_grid(px, py + dy))
			py += dy;
	endtask

	task automatic advance_blocks();
		int dx;
		int dy;
		dx = (dir == 1) ? -cell_pitch : ((dir == 3) ? cell_pitch : 0);
		dy = (dir == 0) ? cell_pitch : ((dir == 2) ? -cell_pitch : 0);
		for (int i = 0; i < block_slots; i++)
		begin
			if (i == slot || !on_grid(bx[i] + dx, by[i] + dy))
			begin
				bx[i] = 0; // loaded slot is filled from the painted origin
				by[i] = 0;
			end
			else
			begin
				bx[i] += dx;
				by[i] += dy;
			end
		end
	endtask

	task automatic press_go();
		@(posedge clock);
		#1;
		go = 1;
		repeat (3)
		begin
			@(negedge clock);
			check_value("plot", 0, plot);
		end
		check_value("game_over", 0, game_over);
	endtask

	task automatic paint_frame();
		int obj;
		int ox;
		int oy;
		int want;
		for (int i = 0; i < objects * window; i++)
		begin
			if (i > 0)
				@(negedge clock);
			obj = i / window;
			if (obj == slot + 1 && i % window == 0)
			begin
				check_true(on_entry_edge(x, y, dir), "new block is not on the entry edge");
				bx[slot] = x;
				by[slot] = y;
			end
			if (i == 0)
				painted_x = x;
			if (obj == 0)
			begin
				ox = px;
				oy = py;
				want = green;
			end
			else
			begin
				ox = bx[obj - 1];
				oy = by[obj - 1];
				want = (ox == 0 && oy == 0) ? black : red;
			end
			check_value("plot", 1, plot);
			check_value("x", ox + i % cell_size, x);
			check_value("y", oy + (i % window) / cell_size, y);
			check_value("colour", want, colour);
		end
		@(negedge clock);
		check_value("plot", 0, plot);
	endtask

	task automatic play_turn(logic [3:0] keys);
		bit known_hit;
		bit edge_hit;
		int waited;
		@(posedge clock);
		#1;
		go = 0;
		{left, right, up, down} = keys;
		move_player(rotate_keys(keys, dir));
		advance_blocks();
		known_hit = 0;
		for (int i = 0; i < block_slots; i++)
			if (bx[i] != 0 && bx[i] == px && by[i] == py)
				known_hit = 1;
		edge_hit = on_entry_edge(px, py, dir); // the unseen new block may land here
		waited = 0;
		@(negedge clock);
		while (!plot && !game_over && waited < 8)
		begin
			@(negedge clock);
			waited++;
		end
		turns++;
		if (game_over)
		begin
			check_true(known_hit || edge_hit, "game over without a block on the player");
			repeat (8)
			begin
				@(negedge clock);
				check_value("game_over", 1, game_over);
				check_value("plot", 0, plot);
			end
			overs++;
			$display("turn %0d: game over after %0d turns, errors %0d", turns, game_turn + 1, errors);
			press_go();
			restart_model();
		end
		else if (plot)
		begin
			check_true(!known_hit, "a block reached the player without game over");
			paint_frame();
			check_true(!(bx[slot] == px && by[slot] == py), "new block on the player without game over");
			if (game_turn >= 1 && game_turn < turns_per_direction)
				check_value("player x", x_last, painted_x);
			if (game_turn == turns_per_direction - 1)
				clamp_seen = 1;
			slot = (slot + 1) % block_slots;
			game_turn++;
			if (game_turn % turns_per_direction == 0)
				dir = (dir + 1) % 4;
			$display("turn %0d: painted, player at %0d,%0d, errors %0d", turns, px, py, errors);
		end
		else
			check_true(0, "neither plot nor game_over followed the turn");
	endtask

	initial
	begin
		logic [3:0] keys;
		clock = 0;
		reset = 0;
		go = 0;
		left = 0;
		right = 0;
		up = 0;
		down = 0;
		void'($urandom(32'ha10e_239e));
		repeat (3) @(posedge clock);
		#1;
		reset = 1;
		repeat (20)
		begin
			@(negedge clock);
			check_value("plot", 0, plot);
			check_value("game_over", 0, game_over);
		end
		press_go();
		$display("idle after reset: done, errors %0d", errors);
		restart_model();
		while (turns < max_turns && !(clamp_seen && overs >= 2))
		begin
			if (game_turn < turns_per_direction)
				keys = 4'b0100; // hold right
			else if (game_turn < 12)
				keys = random_keys();
			else
				keys = chase_keys((slot + block_slots - 1) % block_slots);
			play_turn(keys);
		end
		check_true(clamp_seen, "player never held right through a whole direction");
		check_true(overs > 0, "no collision within the turn limit");
		$display("turns %0d, games over %0d, testbench errors %0d, checker failures %0d",
			turns, overs, errors, dut_i.checker_i.failures);
		if (errors == 0 && dut_i.checker_i.failures == 0)
			$display("** PASS **");
		else
			$display("** FAIL **");
		$finish;
	end

endmodule

//--- verification/dodge_game_checker.sv
`timescale 1ns/1ps

module dodge_game_checker (
	input logic clock,
	input logic reset,
	input logic go,
	input logic plot,
	input logic [7:0] x,
	input logic [6:0] y,
	input dodge_pkg::colour_t colour,
	input logic game_over
);
	import dodge_pkg::*;

	int failures = 0; // assertion failures so far

	plot_or_over: assert property (@(posedge clock) disable iff (!reset)
		!(plot && game_over))
	else
	begin
		$error("plot and game_over are high together");
		failures++;
	end

	// an empty slot has a zero origin, so its black square sits in the corner
	empty_at_zero: assert property (@(posedge clock) disable iff (!reset)
		plot && colour == black |-> (x < cell_size) && (y < cell_size))
	else
	begin
		$error("black pixel %0d,%0d lies outside the empty-slot square", x, y);
		failures++;
	end

	on_screen: assert property (@(posedge clock) disable iff (!reset)
		plot |-> (x <= x_last + cell_size - 1) && (y <= y_last + cell_size - 1))
	else
	begin
		$error("pixel %0d,%0d lies outside the board", x, y);
		failures++;
	end

	// game over only ends on go
	over_holds: assert property (@(posedge clock) disable iff (!reset)
		game_over && !go |=> game_over)
	else
	begin
		$error("game_over fell without go");
		failures++;
	end

	turn_gap: assert property (@(posedge clock) disable iff (!reset)
		$fell(plot) |=> !plot ##1 !plot ##1 !plot)
	else
	begin
		$error("plot came back before spawn, step and check");
		failures++;
	end

endmodule

bind dodge_game dodge_game_checker checker_i (.*);

//--- verilog/dodge_game.sv
`timescale 1ns/1ps

module dodge_game (
	input logic clock,
	input logic reset,
	input logic go,
	input logic left,
	input logic right,
	input logic up,
	input logic down,
	output logic plot,
	output logic [7:0] x,
	output logic [6:0] y,
	output dodge_pkg::colour_t colour,
	output logic game_over
);
	import dodge_pkg::*;

	logic spawn;
	logic step;
	logic clear;
	logic paint_start;
	logic paint_done;
	logic [3:0] slot;
	coord_t spawn_coord;

	board_if board ();

	game_control control_i (
		.clock(clock),
		.reset(reset),
		.go(go),
		.paint_done(paint_done),
		.board(board),
		.spawn(spawn),
		.step(step),
		.clear(clear),
		.paint_start(paint_start),
		.game_over(game_over),
		.slot(slot)
	);

	lane_picker lane_i (
		.clock(clock),
		.reset(reset),
		.spawn(spawn),
		.direction(board.direction),
		.spawn_coord(spawn_coord)
	);

	block_field field_i (
		.clock(clock),
		.reset(reset),
		.clear(clear),
		.step(step),
		.left(left),
		.right(right),
		.up(up),
		.down(down),
		.slot(slot),
		.spawn_coord(spawn_coord),
		.board(board)
	);

	cell_painter painter_i (
		.clock(clock),
		.reset(reset),
		.paint_start(paint_start),
		.board(board),
		.plot(plot),
		.x(x),
		.y(y),
		.colour(colour),
		.paint_done(paint_done)
	);

endmodule

//--- verilog/game_control.sv
`timescale 1ns/1ps

module game_control (
	input logic clock,
	input logic reset,
	input logic go,
	input logic paint_done,
	board_if.control board,
	output logic spawn,
	output logic step,
	output logic clear,
	output logic paint_start,
	output logic game_over,
	output logic [3:0] slot
);
	import dodge_pkg::*;

	enum logic [2:0] {
		st_prepare,
		st_main,
		st_main_wait,
		st_spawn,
		st_step,
		st_check,
		st_paint,
		st_over
	} state, next_state;

	logic [1:0] turn_count;

	always_comb
	begin
		next_state = state;
		case (state)
			st_prepare: next_state = st_main;
			st_main: next_state = go ? st_main_wait : st_main;
			st_main_wait: next_state = go ? st_main_wait : st_spawn; // start on release
			st_spawn: next_state = st_step;
			st_step: next_state = st_check;
			st_check: next_state = board.collision ? st_over : st_paint;
			st_paint: next_state = paint_done ? st_spawn : st_paint;
			st_over: next_state = go ? st_prepare : st_over;
			default: next_state = st_prepare;
		endcase
	end

	always_ff @(posedge clock)
	begin
		if (!reset)
			state <= st_prepare;
		else
			state <= next_state;
	end

	assign spawn = state == st_spawn;
	assign step = state == st_step;
	assign clear = state == st_prepare;
	assign paint_start = (state == st_check) && !board.collision;
	assign game_over = state == st_over;

	// slot advances once the spawned block is loaded, direction turns after every fourth paint
	always_ff @(posedge clock)
	begin
		if (!reset || clear)
		begin
			turn_count <= 2'd0;
			board.direction <= dir_down;
			slot <= 4'd0;
		end
		else
		begin
			if (step)
				slot <= (slot == 4'(block_slots - 1)) ? 4'd0 : slot + 4'd1;
			if (paint_done)
			begin
				turn_count <= turn_count + 2'd1;
				if (turn_count == 2'(turns_per_direction - 1))
					board.direction <= dir_t'(board.direction + 2'd1);
			end
		end
	end

endmodule

//--- verilog/cell_painter.sv
`timescale 1ns/1ps

module cell_painter (
	input logic clock,
	input logic reset,
	input logic paint_start,
	board_if.painter board,
	output logic plot,
	output logic [7:0] x,
	output logic [6:0] y,
	output dodge_pkg::colour_t colour,
	output logic paint_done
);
	import dodge_pkg::*;

	logic active;
	logic [3:0] obj; // 0 is the player, then slots 0 to 9
	logic [4:0] col;
	logic [4:0] row;
	logic last_col;
	logic last_row;
	logic last_obj;
	coord_t origin;

	assign last_col = col == 5'(cell_size - 1);
	assign last_row = row == 5'(cell_size - 1);
	assign last_obj = obj == 4'(objects - 1);

	always_comb
	begin
		if (obj == 4'd0)
		begin
			origin = board.player;
			colour = green;
		end
		else
		begin
			origin = board.blocks[obj - 4'd1];
			colour = (origin != '0) ? red : black;
		end
	end

	always_ff @(posedge clock)
	begin
		if (!reset)
		begin
			active <= 1'b0;
			obj <= 4'd0;
			col <= 5'd0;
			row <= 5'd0;
			paint_done <= 1'b0;
		end
		else
		begin
			paint_done <= active && last_col && last_row && last_obj;
			if (paint_start)
			begin
				active <= 1'b1;
				obj <= 4'd0;
				col <= 5'd0;
				row <= 5'd0;
			end
			else if (active)
			begin
				col <= last_col ? 5'd0 : col + 5'd1; // row-major sweep
				if (last_col)
				begin
					row <= last_row ? 5'd0 : row + 5'd1;
					if (last_row)
					begin
						obj <= last_obj ? 4'd0 : obj + 4'd1;
						if (last_obj)
							active <= 1'b0;
					end
				end
			end
		end
	end

	assign plot = active;
	assign x = origin[14:7] + 8'(col);
	assign y = origin[6:0] + 7'(row);

endmodule

//--- verilog/block_field.sv
`timescale 1ns/1ps

module block_field (
	input logic clock,
	input logic reset,
	input logic clear,
	input logic step,
	input logic left,
	input logic right,
	input logic up,
	input logic down,
	input logic [3:0] slot,
	input dodge_pkg::coord_t spawn_coord,
	board_if.field board
);
	import dodge_pkg::*;

	logic move_left;
	logic move_right;
	logic move_up;
	logic move_down;
	logic [7:0] px;
	logic [6:0] py;
	coord_t next_player;
	coord_t next_blocks [block_slots];
	logic hit;

	// one cell along d, a block past the far edge is removed
	function automatic coord_t advance(coord_t c, dir_t d);
		logic [7:0] cx;
		logic [6:0] cy;
		coord_t result;
		cx = c[14:7];
		cy = c[6:0];
		case (d)
			dir_down: result = (cy == y_last) ? '0 : {cx, cy + 7'(cell_pitch)};
			dir_left: result = (cx == x_first) ? '0 : {cx - 8'(cell_pitch), cy};
			dir_up: result = (cy == y_first) ? '0 : {cx, cy - 7'(cell_pitch)};
			default: result = (cx == x_last) ? '0 : {cx + 8'(cell_pitch), cy};
		endcase
		return result;
	endfunction

	// keys turn with the board
	always_comb
	begin
		case (board.direction)
			dir_down: {move_left, move_right, move_up, move_down} = {left, right, up, down};
			dir_left: {move_left, move_right, move_up, move_down} = {up, down, right, left};
			dir_up: {move_left, move_right, move_up, move_down} = {right, left, down, up};
			default: {move_left, move_right, move_up, move_down} = {down, up, left, right};
		endcase
	end

	always_comb
	begin
		px = board.player[14:7];
		py = board.player[6:0];
		if (move_left && !move_right && px != x_first)
			px = px - 8'(cell_pitch);
		else if (move_right && !move_left && px != x_last)
			px = px + 8'(cell_pitch);
		if (move_up && !move_down && py != y_first)
			py = py - 7'(cell_pitch);
		else if (move_down && !move_up && py != y_last)
			py = py + 7'(cell_pitch);
		next_player = {px, py};
	end

	always_comb
	begin
		hit = 1'b0;
		for (int i = 0; i < block_slots; i++)
		begin
			if (slot == 4'(i))
				next_blocks[i] = spawn_coord; // new block stays on the entry edge this turn
			else if (board.blocks[i] != '0)
				next_blocks[i] = advance(board.blocks[i], board.direction);
			else
				next_blocks[i] = '0;
			if (next_blocks[i] != '0 && next_blocks[i] == next_player)
				hit = 1'b1;
		end
	end

	// collision is taken from the new positions so it is ready in the following cycle
	always_ff @(posedge clock)
	begin
		if (!reset || clear)
		begin
			board.player <= player_start;
			for (int i = 0; i < block_slots; i++)
				board.blocks[i] <= '0;
			board.collision <= 1'b0;
		end
		else if (step)
		begin
			board.player <= next_player;
			board.blocks <= next_blocks;
			board.collision <= hit;
		end
	end

endmodule

//--- verilog/lane_picker.sv
`timescale 1ns/1ps

module lane_picker (
	input logic clock,
	input logic reset,
	input logic spawn,
	input dodge_pkg::dir_t direction,
	output dodge_pkg::coord_t spawn_coord
);
	import dodge_pkg::*;

	logic [7:0] lfsr;
	logic [2:0] raw_lane;
	logic [2:0] prev_lane;
	logic [2:0] lane;
	logic [7:0] x_offset;
	logic [6:0] y_offset;

	always_ff @(posedge clock)
	begin
		if (!reset)
			lfsr <= 8'h5a;
		else
			lfsr <= {lfsr[6:0], lfsr[7] ^ lfsr[5] ^ lfsr[4] ^ lfsr[3]}; // x^8+x^6+x^5+x^4+1
	end

	assign raw_lane = 3'(lfsr % lanes);

	// never land next to the last raw lane, compare in 4 bits so the reset value matches nothing
	always_comb
	begin
		if ({1'b0, raw_lane} == {1'b0, prev_lane} + 4'd1)
			lane = (raw_lane == 3'(lanes - 1)) ? 3'd0 : raw_lane + 3'd1;
		else if ({1'b0, raw_lane} == {1'b0, prev_lane} - 4'd1)
			lane = (raw_lane == 3'd0) ? 3'(lanes - 1) : raw_lane - 3'd1;
		else
			lane = raw_lane;
	end

	assign x_offset = 8'(lane * cell_pitch);
	assign y_offset = 7'(lane * cell_pitch);

	always_ff @(posedge clock)
	begin
		if (!reset)
		begin
			prev_lane <= 3'd7; // no lane yet
			spawn_coord <= '0;
		end
		else if (spawn)
		begin
			prev_lane <= raw_lane;
			case (direction)
				dir_down: spawn_coord <= {x_first + x_offset, y_first};
				dir_left: spawn_coord <= {x_last, y_first + y_offset};
				dir_up: spawn_coord <= {x_first + x_offset, y_last};
				default: spawn_coord <= {x_first, y_first + y_offset};
			endcase
		end
	end

endmodule

//--- verilog/board_if.sv
`timescale 1ns/1ps

interface board_if;
	import dodge_pkg::*;

	coord_t player;
	coord_t blocks [block_slots];
	logic collision;
	dir_t direction;

	modport field (
		input direction,
		output player, blocks, collision
	);

	modport control (
		input collision,
		output direction
	);

	modport painter (
		input player, blocks
	);

endinterface

//--- verilog/dodge_pkg.sv
package dodge_pkg;

	typedef logic [14:0] coord_t; // x in [14:7], y in [6:0], zero marks an empty slot

	typedef enum logic [1:0] {
		dir_down,
		dir_left,
		dir_up,
		dir_right
	} dir_t;

	typedef logic [2:0] colour_t;

	localparam colour_t black = 3'd0;
	localparam colour_t green = 3'd2; // player
	localparam colour_t red = 3'd4; // blocks

	localparam int cell_pitch = 21;
	localparam int cell_size = 20;

	localparam logic [7:0] x_first = 8'd27;
	localparam logic [7:0] x_last = 8'd111;
	localparam logic [6:0] y_first = 7'd7;
	localparam logic [6:0] y_last = 7'd91;

	localparam int lanes = 5;
	localparam int block_slots = 10;
	localparam int objects = 11; // player plus blocks

	localparam coord_t player_start = {8'd69, 7'd49}; // centre cell
	localparam int turns_per_direction = 4;

endpackage
